// ==== hw/l1c_ctrl.sv ====
/*
  L1 cache controller
  tag lookup, four-word line refill with critical word capture,
  and write-through of every store to memory
*/
`timescale 1ns/1ps

module l1c_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                core_req,
  input  l1c_pkg::core_req_t  core_cmd,
  output l1c_pkg::word_t      core_rdata,
  output logic                core_wait,
  output logic                mem_req,
  output logic                mem_write,
  output l1c_pkg::addr_t      mem_addr,
  output l1c_pkg::word_t      mem_wdata,
  output l1c_pkg::access_e    mem_kind,
  input  l1c_pkg::word_t      mem_rdata,
  input  logic                mem_wait,
  output l1c_pkg::index_t     lk_index,
  output logic                lk_read,
  input  l1c_pkg::tag_t       st_tag,
  input  l1c_pkg::line_t      st_line,
  input  logic                st_valid,
  output logic                fill,
  output l1c_pkg::tag_t       fill_tag,
  output l1c_pkg::line_t      fill_line,
  output logic                hit_write,
  output l1c_pkg::core_req_t  cmd,
  input  l1c_pkg::lane_mask_t merge_mask,
  input  l1c_pkg::line_t      merge_line,
  output l1c_pkg::lane_mask_t wr_mask
);

  localparam int cnt_bits = $clog2(l1c_pkg::words_per_line);

  l1c_pkg::ctrl_state_e state;
  l1c_pkg::ctrl_state_e next_state;
  logic [cnt_bits-1:0]  word_cnt;
  l1c_pkg::line_t       refill_buf;
  l1c_pkg::word_t       rdata_q;
  l1c_pkg::word_t       hit_word;
  logic [cnt_bits-1:0]  cmd_word;
  l1c_pkg::tag_t        cmd_tag;
  logic                 hit;
  logic                 idle_accept;
  logic                 wt_phase;
  logic                 beat_done;

  // ====================
  // address fields
  // ====================
  assign cmd_word = cmd.addr[l1c_pkg::offset_bits-1:2];
  assign cmd_tag  = cmd.addr[l1c_pkg::addr_w-1 -: l1c_pkg::tag_bits];
  assign hit      = st_valid && (st_tag == cmd_tag);
  assign hit_word = st_line[cmd_word*l1c_pkg::data_w +: l1c_pkg::data_w];

  assign idle_accept = (state == l1c_pkg::st_idle) && core_req;
  assign wt_phase    = (state == l1c_pkg::st_wt_req) || (state == l1c_pkg::st_wt_wait);
  assign beat_done   = (state == l1c_pkg::st_refill_wait) && !mem_wait;

  // ====================
  // state machine
  // ====================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= l1c_pkg::st_idle;
      word_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      if (state == l1c_pkg::st_lookup)
        word_cnt <= '0;
      else if (beat_done)
        word_cnt <= word_cnt + 1'b1;
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      l1c_pkg::st_idle:
        if (core_req)
          next_state = l1c_pkg::st_lookup;
      l1c_pkg::st_lookup:
        if (cmd.write)
          next_state = l1c_pkg::st_wt_req;
        else if (hit)
          next_state = l1c_pkg::st_idle;
        else
          next_state = l1c_pkg::st_refill_req;
      l1c_pkg::st_refill_req:
        next_state = l1c_pkg::st_refill_wait;
      l1c_pkg::st_refill_wait:
        // last word of the line goes to the fill cycle
        if (!mem_wait)
          next_state = (&word_cnt) ? l1c_pkg::st_fill : l1c_pkg::st_refill_req;
      l1c_pkg::st_fill:
        next_state = l1c_pkg::st_idle;
      l1c_pkg::st_wt_req:
        next_state = l1c_pkg::st_wt_wait;
      l1c_pkg::st_wt_wait:
        if (!mem_wait)
          next_state = l1c_pkg::st_idle;
      default:
        next_state = l1c_pkg::st_idle;
    endcase
  end

  // request latch, refill buffer and returned word
  always_ff @(posedge clk)
  begin
    if (idle_accept)
      cmd <= core_cmd;
    if (beat_done)
    begin
      refill_buf[word_cnt*l1c_pkg::data_w +: l1c_pkg::data_w] <= mem_rdata;
      // requested word as it arrives
      if (word_cnt == cmd_word)
        rdata_q <= mem_rdata;
    end
    if ((state == l1c_pkg::st_lookup) && !cmd.write && hit)
      rdata_q <= hit_word;
  end

  // ====================
  // core side
  // ====================
  assign core_rdata = (state == l1c_pkg::st_lookup) ? hit_word : rdata_q;

  always_comb
  begin
    case (state)
      l1c_pkg::st_idle:    core_wait = core_req;
      l1c_pkg::st_lookup:  core_wait = cmd.write || !hit;
      l1c_pkg::st_fill:    core_wait = 1'b0;
      l1c_pkg::st_wt_wait: core_wait = mem_wait;
      default:             core_wait = 1'b1;
    endcase
  end

  // ====================
  // memory side
  // ====================
  assign mem_req   = (state == l1c_pkg::st_refill_req) || (state == l1c_pkg::st_wt_req);
  assign mem_write = wt_phase;
  assign mem_kind  = wt_phase ? cmd.kind : l1c_pkg::access_word;
  assign mem_addr  = wt_phase ? cmd.addr
                              : {cmd.addr[l1c_pkg::addr_w-1:l1c_pkg::offset_bits],
                                 word_cnt, 2'b00};
  // store data already replicated into its lanes by the merger
  assign mem_wdata = merge_line[l1c_pkg::data_w-1:0];

  // line store
  assign lk_index  = (state == l1c_pkg::st_idle)
                     ? core_cmd.addr[l1c_pkg::offset_bits +: l1c_pkg::index_bits]
                     : cmd.addr[l1c_pkg::offset_bits +: l1c_pkg::index_bits];
  assign lk_read   = idle_accept;
  assign fill      = (state == l1c_pkg::st_fill);
  assign fill_tag  = cmd_tag;
  assign fill_line = refill_buf;
  assign hit_write = (state == l1c_pkg::st_lookup) && cmd.write && hit;
  assign wr_mask   = hit_write ? merge_mask : '0;

  // ====================
  // assertions
  // ====================
  a_req_pulse: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req);

  a_no_dual_write: assert property (@(posedge clk) disable iff (rst) !(fill && hit_write));

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state inside {l1c_pkg::st_idle, l1c_pkg::st_lookup, l1c_pkg::st_refill_req,
                  l1c_pkg::st_refill_wait, l1c_pkg::st_fill, l1c_pkg::st_wt_req,
                  l1c_pkg::st_wt_wait});

endmodule

// ==== hw/l1c_inst.sv ====
/*
  L1 cache top level
  direct mapped, 64 lines of four words, write-through without
  write allocate; joins the controller, line store and store merger
*/
`timescale 1ns/1ps

module l1c_inst (
  input  logic               clk,
  input  logic               rst,
  input  logic               core_req,
  input  l1c_pkg::core_req_t core_cmd,
  output l1c_pkg::word_t     core_rdata,
  output logic               core_wait,
  output logic               mem_req,
  output logic               mem_write,
  output l1c_pkg::addr_t     mem_addr,
  output l1c_pkg::word_t     mem_wdata,
  output l1c_pkg::access_e   mem_kind,
  input  l1c_pkg::word_t     mem_rdata,
  input  logic               mem_wait
);

  // controller to line store
  l1c_pkg::index_t     lk_index;
  logic                lk_read;
  logic                fill;
  l1c_pkg::tag_t       fill_tag;
  l1c_pkg::line_t      fill_line;
  logic                hit_write;
  l1c_pkg::lane_mask_t wr_mask;

  // line store read port
  l1c_pkg::tag_t       st_tag;
  l1c_pkg::line_t      st_line;
  logic                st_valid;

  // store merger
  l1c_pkg::core_req_t  cmd;
  l1c_pkg::lane_mask_t merge_mask;
  l1c_pkg::line_t      merge_line;

  l1c_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_cmd   (core_cmd),
    .core_rdata (core_rdata),
    .core_wait  (core_wait),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_kind   (mem_kind),
    .mem_rdata  (mem_rdata),
    .mem_wait   (mem_wait),
    .lk_index   (lk_index),
    .lk_read    (lk_read),
    .st_tag     (st_tag),
    .st_line    (st_line),
    .st_valid   (st_valid),
    .fill       (fill),
    .fill_tag   (fill_tag),
    .fill_line  (fill_line),
    .hit_write  (hit_write),
    .cmd        (cmd),
    .merge_mask (merge_mask),
    .merge_line (merge_line),
    .wr_mask    (wr_mask)
  );

  l1c_line_store u_store (
    .clk        (clk),
    .rst        (rst),
    .lk_index   (lk_index),
    .lk_read    (lk_read),
    .st_tag     (st_tag),
    .st_line    (st_line),
    .st_valid   (st_valid),
    .fill       (fill),
    .fill_tag   (fill_tag),
    .fill_line  (fill_line),
    .hit_write  (hit_write),
    .wr_mask    (wr_mask),
    .merge_line (merge_line)
  );

  l1c_store_merge u_merge (
    .cmd        (cmd),
    .merge_mask (merge_mask),
    .merge_line (merge_line)
  );

endmodule

// ==== hw/l1c_line_store.sv ====
/*
  L1 cache line store
  tag array, data array and valid bits for 64 lines; registered
  read, full line fill and byte-masked write on a store hit
*/
`timescale 1ns/1ps

module l1c_line_store (
  input  logic                clk,
  input  logic                rst,
  input  l1c_pkg::index_t     lk_index,
  input  logic                lk_read,
  output l1c_pkg::tag_t       st_tag,
  output l1c_pkg::line_t      st_line,
  output logic                st_valid,
  input  logic                fill,
  input  l1c_pkg::tag_t       fill_tag,
  input  l1c_pkg::line_t      fill_line,
  input  logic                hit_write,
  input  l1c_pkg::lane_mask_t wr_mask,
  input  l1c_pkg::line_t      merge_line
);

  localparam int n_lines = 2 ** l1c_pkg::index_bits;

  l1c_pkg::tag_t        tag_mem  [n_lines];
  l1c_pkg::line_t       data_mem [n_lines];
  logic [n_lines-1:0]   valid_q;

  // valid bits
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q  <= '0;
      st_valid <= 1'b0;
    end
    else
    begin
      if (fill)
        valid_q[lk_index] <= 1'b1;
      if (lk_read)
        st_valid <= valid_q[lk_index];
    end
  end

  // ====================
  // tag and data arrays
  // ====================
  always_ff @(posedge clk)
  begin
    if (lk_read)
    begin
      st_tag  <= tag_mem[lk_index];
      st_line <= data_mem[lk_index];
    end
    if (fill)
    begin
      tag_mem[lk_index]  <= fill_tag;
      data_mem[lk_index] <= fill_line;
    end
    else if (hit_write)
    begin
      for (int i = 0; i < l1c_pkg::lane_bits; i++)
      begin
        if (wr_mask[i])
          data_mem[lk_index][i*8 +: 8] <= merge_line[i*8 +: 8];
      end
    end
  end

  a_one_writer: assert property (@(posedge clk) disable iff (rst) !(fill && hit_write));

endmodule

// ==== hw/l1c_pkg.sv ====
/*
  L1 cache shared definitions
  geometry, vector types, access and state encodings and the
  core request bundle used by the controller, line store and merger
*/
package l1c_pkg;

  // ====================
  // geometry
  // ====================
  localparam int addr_w         = 32;
  localparam int data_w         = 32;
  localparam int index_bits     = 6;
  localparam int offset_bits    = 4;
  localparam int tag_bits       = addr_w - index_bits - offset_bits;
  localparam int words_per_line = 4;
  localparam int line_bits      = words_per_line * data_w;
  localparam int lane_bits      = line_bits / 8;

  // ====================
  // vector types
  // ====================
  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [data_w-1:0]     word_t;
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [line_bits-1:0]  line_t;
  // one bit per byte of the line, set means write
  typedef logic [lane_bits-1:0]  lane_mask_t;

  typedef enum logic [1:0] {
    access_byte,
    access_half,
    access_word
  } access_e;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_refill_req,
    st_refill_wait,
    st_fill,
    st_wt_req,
    st_wt_wait
  } ctrl_state_e;

  // request as presented by the core
  typedef struct packed {
    addr_t   addr;
    word_t   wdata;
    logic    write;
    access_e kind;
  } core_req_t;

endpackage

// ==== hw/l1c_store_merge.sv ====
/*
  L1 cache store merger
  byte-lane mask and lane-aligned line data for a store
*/
`timescale 1ns/1ps

module l1c_store_merge (
  input  l1c_pkg::core_req_t  cmd,
  output l1c_pkg::lane_mask_t merge_mask,
  output l1c_pkg::line_t      merge_line
);

  logic [3:0]     word_lanes;
  l1c_pkg::word_t rep_word;
  logic [1:0]     word_off;

  assign word_off = cmd.addr[l1c_pkg::offset_bits-1:2];

  // lanes inside one word and the data spread over them
  always_comb
  begin
    case (cmd.kind)
      l1c_pkg::access_byte:
      begin
        word_lanes = 4'b0001 << cmd.addr[1:0];
        rep_word   = {4{cmd.wdata[7:0]}};
      end
      l1c_pkg::access_half:
      begin
        word_lanes = cmd.addr[1] ? 4'b1100 : 4'b0011;
        rep_word   = {2{cmd.wdata[15:0]}};
      end
      default:
      begin
        word_lanes = 4'b1111;
        rep_word   = cmd.wdata;
      end
    endcase
  end

  // word offset picks the four-lane group
  assign merge_mask = l1c_pkg::lane_mask_t'(word_lanes) << {word_off, 2'b00};
  assign merge_line = {l1c_pkg::words_per_line{rep_word}};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the L1 cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_l1c \
  -o sim_l1c \
  -f tb.f

out=$(./obj_dir/sim_l1c)
printf '%s\n' "$out"

# the run passes only if the testbench reported a pass
printf '%s\n' "$out" | grep -qx "TEST PASSED"

// ==== tb.f ====
hw/l1c_pkg.sv
hw/l1c_store_merge.sv
hw/l1c_line_store.sv
hw/l1c_ctrl.sv
hw/l1c_inst.sv
verification/l1c_checker.sv
verification/tb_l1c.sv

// ==== verification/l1c_cases.txt ====
# op addr wdata kind expected_rdata expected_mem_reqs
# op R or W, kind B H or W, hex except the last column in decimal
R 00001004 00000000 W 5a5a0401 4
R 00001000 00000000 W 5a5a0400 0
R 00001008 00000000 W 5a5a0402 0
R 0000100c 00000000 W 5a5a0403 0
R 00002004 00000000 W 5a5a0801 4
R 00001004 00000000 W 5a5a0401 4
W 00001001 000000ab B 00000000 1
R 00001000 00000000 W 5a5aab00 0
W 0000100a 0000beef H 00000000 1
R 00001008 00000000 W beef0402 0
W 0000100c 12345678 W 00000000 1
R 0000100c 00000000 W 12345678 0
W 00001007 000000c3 B 00000000 1
R 00001004 00000000 W c35a0401 0
W 00003010 00007e55 H 00000000 1
R 00003010 00000000 W 5a5a7e55 4
R 00003014 00000000 W 5a5a0c05 0
W 00004022 00000099 B 00000000 1
R 00004020 00000000 W 5a991008 4

// ==== verification/l1c_checker.sv ====
/*
  L1 cache result checker
  counts memory requests per operation, compares read data and
  request counts at completion and reports one line per case
*/
`timescale 1ns/1ps

module l1c_checker (
  input  logic               clk,
  input  logic               rst,
  input  logic               core_req,
  input  l1c_pkg::core_req_t core_cmd,
  input  l1c_pkg::word_t     core_rdata,
  input  logic               core_wait,
  input  logic               mem_req,
  input  l1c_pkg::word_t     exp_rdata,
  input  int                 exp_reqs,
  input  int                 case_no,
  input  logic               abort,
  output int                 pass_cnt,
  output int                 fail_cnt
);

  int   req_cnt = 0;
  int   passes  = 0;
  int   fails   = 0;
  logic was_rst = 1'b0;
  logic bad;

  assign pass_cnt = passes;
  assign fail_cnt = fails;

  always @(posedge clk)
  begin
    if (rst)
    begin
      req_cnt = 0;
      was_rst = 1'b1;
    end
    else
    begin
      // ====================
      // values right after reset
      // ====================
      if (was_rst)
      begin
        was_rst = 1'b0;
        bad = 1'b0;
        if (core_wait !== 1'b0)
        begin
          $display("[FAIL] reset core_wait got %0h expected 0", core_wait);
          bad = 1'b1;
        end
        if (mem_req !== 1'b0)
        begin
          $display("[FAIL] reset mem_req got %0h expected 0", mem_req);
          bad = 1'b1;
        end
        if (bad)
          fails++;
        else
        begin
          $display("[PASS] reset state");
          passes++;
        end
      end

      if (mem_req)
        req_cnt++;

      // ====================
      // operation results
      // ====================
      if (abort)
      begin
        $display("case %0d timed out, core_wait never dropped", case_no);
        fails++;
      end
      else if (core_req && !core_wait)
      begin
        bad = 1'b0;
        if (!core_cmd.write && core_rdata !== exp_rdata)
        begin
          $display("[FAIL] case %0d core_rdata got %08h expected %08h",
                   case_no, core_rdata, exp_rdata);
          bad = 1'b1;
        end
        if (req_cnt != exp_reqs)
        begin
          $display("[FAIL] case %0d mem_req count got %0h expected %0h",
                   case_no, req_cnt, exp_reqs);
          bad = 1'b1;
        end
        if (bad)
          fails++;
        else
        begin
          $display("[PASS] case %0d %s addr %08h", case_no,
                   core_cmd.write ? "write" : "read", core_cmd.addr);
          passes++;
        end
        // next operation counts from zero
        req_cnt = 0;
      end
    end
  end

endmodule

// ==== verification/tb_l1c.sv ====
/*
  L1 cache testbench
  clock, reset, a memory model with random wait states and a
  driver that plays the cases file against the DUT
*/
`timescale 1ns/1ps

module tb_l1c;

  logic               clk;
  logic               rst;
  logic               core_req;
  l1c_pkg::core_req_t core_cmd;
  l1c_pkg::word_t     core_rdata;
  logic               core_wait;
  logic               mem_req;
  logic               mem_write;
  l1c_pkg::addr_t     mem_addr;
  l1c_pkg::word_t     mem_wdata;
  l1c_pkg::access_e   mem_kind;
  l1c_pkg::word_t     mem_rdata = '0;
  logic               mem_wait  = 1'b0;

  // expected values for the checker
  l1c_pkg::word_t     exp_rdata;
  int                 exp_reqs;
  int                 case_no;
  logic               abort;
  int                 pass_cnt;
  int                 fail_cnt;

  // memory model state
  l1c_pkg::word_t     mem [l1c_pkg::addr_t];
  l1c_pkg::addr_t     mem_wa;
  logic [31:0]        rng       = 32'h8559_1ff1;
  logic [1:0]         wait_left = 2'd0;

  l1c_inst u_dut (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_cmd   (core_cmd),
    .core_rdata (core_rdata),
    .core_wait  (core_wait),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_kind   (mem_kind),
    .mem_rdata  (mem_rdata),
    .mem_wait   (mem_wait)
  );

  l1c_checker u_chk (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_cmd   (core_cmd),
    .core_rdata (core_rdata),
    .core_wait  (core_wait),
    .mem_req    (mem_req),
    .exp_rdata  (exp_rdata),
    .exp_reqs   (exp_reqs),
    .case_no    (case_no),
    .abort      (abort),
    .pass_cnt   (pass_cnt),
    .fail_cnt   (fail_cnt)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // untouched words hold their word address xor a fixed pattern
  function automatic l1c_pkg::word_t read_word(input l1c_pkg::addr_t wa);
    if (mem.exists(wa))
      return mem[wa];
    return wa ^ 32'h5a5a_0000;
  endfunction

  function automatic l1c_pkg::word_t put_lanes(input l1c_pkg::word_t old,
                                               input l1c_pkg::addr_t a,
                                               input l1c_pkg::word_t d,
                                               input l1c_pkg::access_e k);
    logic [3:0]     lanes;
    l1c_pkg::word_t w;
    case (k)
      l1c_pkg::access_byte: lanes = 4'b0001 << a[1:0];
      l1c_pkg::access_half: lanes = a[1] ? 4'b1100 : 4'b0011;
      default:              lanes = 4'b1111;
    endcase
    w = old;
    for (int i = 0; i < 4; i++)
    begin
      if (lanes[i])
        w[i*8 +: 8] = d[i*8 +: 8];
    end
    return w;
  endfunction

  // ====================
  // memory model
  // ====================
  always @(negedge clk)
  begin
    if (mem_req)
    begin
      mem_wa = {2'b00, mem_addr[31:2]};
      rng = lcg_next(rng);
      wait_left = rng[31:30];
      mem_wait <= (rng[31:30] != 2'd0);
      if (mem_write)
        mem[mem_wa] = put_lanes(read_word(mem_wa), mem_addr, mem_wdata, mem_kind);
      else
        mem_rdata <= read_word(mem_wa);
    end
    else if (wait_left != 2'd0)
    begin
      wait_left = wait_left - 2'd1;
      mem_wait <= (wait_left != 2'd0);
    end
  end

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  task automatic run_case(input int num, input logic [7:0] op, input l1c_pkg::addr_t a,
                          input l1c_pkg::word_t d, input logic [7:0] kc,
                          input l1c_pkg::word_t e, input int r, output logic late);
    int   cyc;
    logic done;
    @(negedge clk);
    core_req       = 1'b1;
    core_cmd.addr  = a;
    core_cmd.wdata = d;
    core_cmd.write = (op == "W");
    case (kc)
      "B":     core_cmd.kind = l1c_pkg::access_byte;
      "H":     core_cmd.kind = l1c_pkg::access_half;
      default: core_cmd.kind = l1c_pkg::access_word;
    endcase
    exp_rdata = e;
    exp_reqs  = r;
    case_no   = num;
    cyc  = 0;
    done = 1'b0;
    // completion is the edge with core_wait low
    while (!done && cyc < 200)
    begin
      @(posedge clk);
      done = !core_wait;
      cyc++;
    end
    late = !done;
  endtask

  // ====================
  // stimulus
  // ====================
  initial
  begin
    int             fd;
    int             fields;
    int             n_cases;
    int             r;
    string          line;
    logic [7:0]     op;
    logic [7:0]     kc;
    l1c_pkg::addr_t a;
    l1c_pkg::word_t d;
    l1c_pkg::word_t e;
    logic           late;
    logic           bad_file;

    rst       = 1'b1;
    core_req  = 1'b0;
    core_cmd  = '0;
    exp_rdata = '0;
    exp_reqs  = 0;
    case_no   = 0;
    abort     = 1'b0;
    late      = 1'b0;
    bad_file  = 1'b0;
    n_cases   = 0;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fd = $fopen("verification/l1c_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open verification/l1c_cases.txt");
      bad_file = 1'b1;
    end
    else
    begin
      while (!late && $fgets(line, fd) != 0)
      begin
        if (line.len() < 2 || line.getc(0) == "#")
          continue;
        fields = $sscanf(line, "%c %h %h %c %h %d", op, a, d, kc, e, r);
        if (fields != 6)
        begin
          $display("malformed line in cases file: %s", line);
          bad_file = 1'b1;
          continue;
        end
        n_cases++;
        run_case(n_cases, op, a, d, kc, e, r, late);
      end
      $fclose(fd);
    end

    // let the checker report the stuck case
    if (late)
    begin
      @(negedge clk);
      abort = 1'b1;
      @(negedge clk);
      abort = 1'b0;
    end
    @(negedge clk);
    core_req = 1'b0;
    @(negedge clk);

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (!late && !bad_file && n_cases > 0 && fail_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
